// File: cache_top.f
+incdir+source
source/cache_pkg.sv
source/cache_line_array.sv
source/cache_controller.sv
source/main_memory.sv
source/cache_top.sv
tests/cache_top_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f cache_top.f \
		--top-module cache_top_tb -o cache_sim
	./obj_dir/cache_sim | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tests/cache_top_tb.sv
`include "cache_params.svh"

module cache_top_tb import cache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 3;
  localparam int num_directed = 10;
  localparam int num_random   = 600;
  localparam int cycle_limit  =
    (num_directed + num_random) * (`CACHE_MEM_LATENCY + 12) + reset_cycles;

  // random requests stay inside a 32 word window
  localparam logic [`CACHE_ADDR_WIDTH-1:0] window_base = `CACHE_ADDR_WIDTH'('h2c0);

  // two addresses on set 5 with different tags
  localparam logic [`CACHE_ADDR_WIDTH-1:0] addr_a = `CACHE_ADDR_WIDTH'(5);
  localparam logic [`CACHE_ADDR_WIDTH-1:0] addr_b = `CACHE_ADDR_WIDTH'(13);

  logic      clk = 1'b0;
  logic      rst;
  cpu_req_t  req;
  logic      req_valid;
  logic      req_ready;
  cpu_resp_t resp;
  logic      resp_valid;
  logic      resp_ready;

  // reference model of memory and cache tags
  logic [`CACHE_DATA_WIDTH-1:0] shadow_mem [2 ** `CACHE_ADDR_WIDTH];
  logic                         model_valid [`CACHE_LINES];
  logic [`CACHE_TAG_WIDTH-1:0]  model_tag [`CACHE_LINES];

  logic [31:0] rand_state;
  int          cycle_count;
  int          hit_count;
  int          miss_count;

  cache_top cache_top_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  task automatic stop_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      stop_run("a response did not match the reference model");
    end
  endtask

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic next_ready(logic stall_allowed);
    logic [31:0] r;
    if (!stall_allowed) begin
      return 1'b1;
    end
    r = next_random();
    // ready about three cycles in four
    return r[31:30] != 2'b00;
  endfunction

  // one request from a falling edge with the DUT idle, returns on the
  // falling edge after the response transferred
  task automatic run_request(string name, logic write, logic [`CACHE_ADDR_WIDTH-1:0] addr,
                             logic [`CACHE_DATA_WIDTH-1:0] wdata, logic stall_allowed);
    cpu_resp_t                   exp_resp;
    cpu_resp_t                   held;
    logic [`CACHE_SET_BITS-1:0]  set_idx;
    logic [`CACHE_TAG_WIDTH-1:0] tag;
    int                          waited;
    logic                        seen;
    logic                        done;

    set_idx = addr[`CACHE_SET_BITS-1:0];
    tag     = addr[`CACHE_ADDR_WIDTH-1:`CACHE_SET_BITS];

    // expectation comes from the model state before this access
    exp_resp.hit = model_valid[set_idx] && (model_tag[set_idx] == tag);
    if (write) begin
      exp_resp.rdata    = '0;
      shadow_mem[addr]  = wdata;
    end else begin
      exp_resp.rdata = shadow_mem[addr];
    end
    model_valid[set_idx] = 1'b1;
    model_tag[set_idx]   = tag;

    check_value({name, " req_ready when idle"}, 64'(1), 64'(req_ready));
    check_value({name, " resp_valid when idle"}, 64'(0), 64'(resp_valid));

    req.write    = write;
    req.addr.raw = addr;
    req.wdata    = wdata;
    req_valid    = 1'b1;
    resp_ready   = next_ready(stall_allowed);

    // accepted on the rising edge in between
    @(negedge clk);
    req_valid = 1'b0;
    waited    = 1;
    seen      = 1'b0;
    done      = 1'b0;

    while (!done) begin
      resp_ready = next_ready(stall_allowed);
      check_value({name, " req_ready while busy"}, 64'(0), 64'(req_ready));
      if (resp_valid) begin
        if (!seen) begin
          held = resp;
          seen = 1'b1;
          // read hit rises two edges after acceptance
          if (!write && exp_resp.hit) begin
            check_value({name, " hit latency"}, 64'(2), 64'(waited - 1));
          end
        end else begin
          check_value({name, " held resp"}, 64'(held), 64'(resp));
        end
        if (resp_ready) begin
          check_value({name, " rdata"}, 64'(exp_resp.rdata), 64'(resp.rdata));
          check_value({name, " hit"}, 64'(exp_resp.hit), 64'(resp.hit));
          if (resp.hit) begin
            hit_count++;
          end else begin
            miss_count++;
          end
          done = 1'b1;
        end
      end
      @(negedge clk);
      waited++;
    end

    // delivered once, no second beat
    check_value({name, " resp_valid after transfer"}, 64'(0), 64'(resp_valid));
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_run($sformatf("timeout: the cache did not finish within %0d cycles", cycle_limit));
  end

  initial begin
    logic [31:0]                  r;
    logic [`CACHE_ADDR_WIDTH-1:0] addr;
    logic [`CACHE_DATA_WIDTH-1:0] data;

    rst        = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b1;
    rand_state = 32'h083e_5de0;
    hit_count  = 0;
    miss_count = 0;
    for (int a = 0; a < 2 ** `CACHE_ADDR_WIDTH; a++) begin
      shadow_mem[a] = '0;
    end
    for (int s = 0; s < `CACHE_LINES; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end

    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;

    check_value("reset req_ready", 64'(1), 64'(req_ready));
    check_value("reset resp_valid", 64'(0), 64'(resp_valid));

    // cold miss, then repeat hit
    run_request("first read a", 1'b0, addr_a, '0, 1'b0);
    run_request("second read a", 1'b0, addr_a, '0, 1'b0);

    // write through and line update
    run_request("write a", 1'b1, addr_a, 32'h5a5a_0001, 1'b0);
    run_request("read a after write", 1'b0, addr_a, '0, 1'b0);

    // a and b share set 5 and evict each other
    run_request("write b", 1'b1, addr_b, 32'ha5a5_0002, 1'b0);
    run_request("conflict read a 1", 1'b0, addr_a, '0, 1'b0);
    run_request("conflict read b 1", 1'b0, addr_b, '0, 1'b0);
    run_request("conflict read a 2", 1'b0, addr_a, '0, 1'b0);
    run_request("conflict read b 2", 1'b0, addr_b, '0, 1'b0);
    run_request("read b again", 1'b0, addr_b, '0, 1'b0);

    // random mix with back-pressure
    for (int i = 0; i < num_random; i++) begin
      r    = next_random();
      addr = window_base + `CACHE_ADDR_WIDTH'(r[20:16]);
      data = next_random();
      run_request($sformatf("random %0d", i), r[27], addr, data, 1'b1);
    end

    $display("requests %0d, hits %0d, misses %0d, cycles %0d",
             num_directed + num_random, hit_count, miss_count, cycle_count);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: source/cache_top.sv
`include "cache_params.svh"

module cache_top import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  cpu_req_t  req,
  input  logic      req_valid,
  output logic      req_ready,
  output cpu_resp_t resp,
  output logic      resp_valid,
  input  logic      resp_ready
);

  // controller to line array
  logic [`CACHE_SET_BITS-1:0] rd_set;
  line_entry_t                rd_entry;
  logic                       wr_en;
  logic [`CACHE_SET_BITS-1:0] wr_set;
  line_entry_t                wr_entry;

  // controller to main memory
  mem_req_t                     mem_req;
  logic                         mem_req_valid;
  logic                         mem_req_ready;
  logic [`CACHE_DATA_WIDTH-1:0] mem_rdata;
  logic                         mem_rdata_valid;

  cache_controller controller_i (
    .clk             (clk),
    .rst             (rst),
    .req             (req),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .resp            (resp),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .rd_set          (rd_set),
    .rd_entry        (rd_entry),
    .wr_en           (wr_en),
    .wr_set          (wr_set),
    .wr_entry        (wr_entry),
    .mem_req         (mem_req),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_rdata       (mem_rdata),
    .mem_rdata_valid (mem_rdata_valid)
  );

  cache_line_array line_array_i (
    .clk      (clk),
    .rst      (rst),
    .rd_set   (rd_set),
    .wr_en    (wr_en),
    .wr_set   (wr_set),
    .wr_entry (wr_entry),
    .rd_entry (rd_entry)
  );

  main_memory memory_i (
    .clk             (clk),
    .rst             (rst),
    .mem_req         (mem_req),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .mem_rdata       (mem_rdata),
    .mem_rdata_valid (mem_rdata_valid)
  );

endmodule

// File: source/main_memory.sv
`include "cache_params.svh"

module main_memory import cache_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  mem_req_t                     mem_req,
  input  logic                         mem_req_valid,
  output logic                         mem_req_ready,
  output logic [`CACHE_DATA_WIDTH-1:0] mem_rdata,
  output logic                         mem_rdata_valid
);

  localparam int cnt_w = $clog2(`CACHE_MEM_LATENCY + 1);
  localparam logic [cnt_w-1:0] lat_last = cnt_w'(`CACHE_MEM_LATENCY - 1);

  logic [`CACHE_DATA_WIDTH-1:0] words [2 ** `CACHE_ADDR_WIDTH];

  logic                         busy_q;
  logic [cnt_w-1:0]             cnt_q;
  logic [`CACHE_ADDR_WIDTH-1:0] rd_addr_q;
  logic                         accept;
  logic                         rd_done;

  // memory powers up cleared
  initial begin
    for (int i = 0; i < 2 ** `CACHE_ADDR_WIDTH; i++) begin
      words[i] = '0;
    end
  end

  assign mem_req_ready = !busy_q;
  assign accept        = mem_req_valid && mem_req_ready;
  assign rd_done       = busy_q && (cnt_q == '0);

  // latency counter, busy for the whole read
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q          <= 1'b0;
      cnt_q           <= '0;
      mem_rdata_valid <= 1'b0;
    end else begin
      mem_rdata_valid <= rd_done;
      if (accept && !mem_req.write) begin
        busy_q <= 1'b1;
        cnt_q  <= lat_last;
      end else if (rd_done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - cnt_w'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && mem_req.write) begin
      words[mem_req.addr.raw] <= mem_req.wdata;
    end
    if (accept && !mem_req.write) begin
      rd_addr_q <= mem_req.addr.raw;
    end
    if (rd_done) begin
      mem_rdata <= words[rd_addr_q];
    end
  end

  // read data only ever follows an accepted read by the fixed latency
  // valid is first sampled one edge after it is set
  a_read_latency: assert property (
    @(posedge clk) disable iff (rst)
    mem_rdata_valid |-> $past(accept && !mem_req.write, `CACHE_MEM_LATENCY + 1)
  );

endmodule

// File: source/cache_controller.sv
`include "cache_params.svh"

module cache_controller import cache_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  // processor side
  input  cpu_req_t                     req,
  input  logic                         req_valid,
  output logic                         req_ready,
  output cpu_resp_t                    resp,
  output logic                         resp_valid,
  input  logic                         resp_ready,
  // line array
  output logic [`CACHE_SET_BITS-1:0]   rd_set,
  input  line_entry_t                  rd_entry,
  output logic                         wr_en,
  output logic [`CACHE_SET_BITS-1:0]   wr_set,
  output line_entry_t                  wr_entry,
  // main memory
  output mem_req_t                     mem_req,
  output logic                         mem_req_valid,
  input  logic                         mem_req_ready,
  input  logic [`CACHE_DATA_WIDTH-1:0] mem_rdata,
  input  logic                         mem_rdata_valid
);

  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_lookup    = 3'd1;
  localparam logic [2:0] st_compare   = 3'd2;
  localparam logic [2:0] st_mem_write = 3'd3;
  localparam logic [2:0] st_mem_read  = 3'd4;
  localparam logic [2:0] st_wait_fill = 3'd5;
  localparam logic [2:0] st_respond   = 3'd6;

  logic [2:0] state_q;
  logic [2:0] state_d;

  // accepted request and the response being built
  cpu_req_t  req_q;
  cpu_resp_t resp_q;

  logic hit;
  logic req_fire;
  logic mem_fire;
  logic fill_done;

  // tag and valid compare against the registered line
  assign hit = rd_entry.valid && (rd_entry.tag == req_q.addr.fields.tag);

  assign req_fire  = req_valid && req_ready;
  assign mem_fire  = mem_req_valid && mem_req_ready;
  assign fill_done = (state_q == st_wait_fill) && !req_q.write && mem_rdata_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_valid) state_d = st_lookup;
      end
      st_lookup: begin
        state_d = st_compare;
      end
      st_compare: begin
        if (req_q.write) begin
          state_d = st_mem_write;
        end else if (hit) begin
          state_d = st_respond;
        end else begin
          state_d = st_mem_read;
        end
      end
      st_mem_write: begin
        if (mem_req_ready) state_d = st_wait_fill;
      end
      st_mem_read: begin
        if (mem_req_ready) state_d = st_wait_fill;
      end
      st_wait_fill: begin
        // a write has already updated the line, so it moves straight on
        if (req_q.write || mem_rdata_valid) state_d = st_respond;
      end
      st_respond: begin
        if (resp_ready) state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req;
    end
    // hit state is captured before any line update
    if (state_q == st_compare) begin
      resp_q.hit   <= hit;
      resp_q.rdata <= (!req_q.write && hit) ? rd_entry.data : '0;
    end
    if (fill_done) begin
      resp_q.rdata <= mem_rdata;
    end
  end

  assign req_ready  = (state_q == st_idle);
  assign resp       = resp_q;
  assign resp_valid = (state_q == st_respond);

  assign rd_set = req_q.addr.fields.set;

  // line update on the memory write edge or on refill data
  assign wr_en          = (mem_fire && req_q.write) || fill_done;
  assign wr_set         = req_q.addr.fields.set;
  assign wr_entry.valid = 1'b1;
  assign wr_entry.tag   = req_q.addr.fields.tag;
  assign wr_entry.data  = req_q.write ? req_q.wdata : mem_rdata;

  assign mem_req.write = req_q.write;
  assign mem_req.addr  = req_q.addr;
  assign mem_req.wdata = req_q.wdata;
  assign mem_req_valid = (state_q == st_mem_write) || (state_q == st_mem_read);

  // held response does not change until it transfers
  a_resp_stable: assert property (
    @(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  );

  // memory traffic starts only after lookup and compare of a new request
  // never while a response is still pending
  a_no_mem_during_resp: assert property (
    @(posedge clk) disable iff (rst)
    $rose(mem_req_valid) |-> !resp_valid && $past(req_fire, 3)
  );

endmodule

// File: source/cache_line_array.sv
`include "cache_params.svh"

module cache_line_array import cache_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`CACHE_SET_BITS-1:0] rd_set,
  input  logic                       wr_en,
  input  logic [`CACHE_SET_BITS-1:0] wr_set,
  input  line_entry_t                wr_entry,
  output line_entry_t                rd_entry
);

  // per-set storage, valid bits kept apart so they can clear on reset
  logic [`CACHE_LINES-1:0]      valid_q;
  logic [`CACHE_TAG_WIDTH-1:0]  tag_q [`CACHE_LINES];
  logic [`CACHE_DATA_WIDTH-1:0] data_q [`CACHE_LINES];

  // one write enable per line
  logic [`CACHE_LINES-1:0] line_we;

  // demux of the write strobe onto the addressed line
  always_comb begin
    line_we = '0;
    line_we[wr_set] = wr_en;
  end

  for (genvar i = 0; i < `CACHE_LINES; i++) begin : g_line

    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q[i] <= 1'b0;
      end else if (line_we[i]) begin
        valid_q[i] <= wr_entry.valid;
      end
    end

    always_ff @(posedge clk) begin
      if (line_we[i]) begin
        tag_q[i]  <= wr_entry.tag;
        data_q[i] <= wr_entry.data;
      end
    end

  end

  // registered read of the addressed set
  // returns the contents before a write in the same cycle
  always_ff @(posedge clk) begin
    rd_entry.valid <= valid_q[rd_set];
    rd_entry.tag   <= tag_q[rd_set];
    rd_entry.data  <= data_q[rd_set];
  end

  // the controller must present a known set with every line write
  a_wr_set_known: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> !$isunknown(wr_set)
  );

endmodule

// File: source/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

  // tag in the upper bits, set index in the lower bits
  typedef struct packed {
    logic [`CACHE_TAG_WIDTH-1:0] tag;
    logic [`CACHE_SET_BITS-1:0]  set;
  } addr_fields_t;

  // one address word, seen whole by memory and split by the cache
  typedef union packed {
    logic [`CACHE_ADDR_WIDTH-1:0] raw;
    addr_fields_t                 fields;
  } cache_addr_t;

  // processor request, one full word
  typedef struct packed {
    logic                         write;
    cache_addr_t                  addr;
    logic [`CACHE_DATA_WIDTH-1:0] wdata;
  } cpu_req_t;

  // processor response
  // rdata is zero for writes, hit is the state before the access
  typedef struct packed {
    logic [`CACHE_DATA_WIDTH-1:0] rdata;
    logic                         hit;
  } cpu_resp_t;

  // request toward main memory
  typedef struct packed {
    logic                         write;
    cache_addr_t                  addr;
    logic [`CACHE_DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  // contents of one cache line
  typedef struct packed {
    logic                         valid;
    logic [`CACHE_TAG_WIDTH-1:0]  tag;
    logic [`CACHE_DATA_WIDTH-1:0] data;
  } line_entry_t;

endpackage

// File: source/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address width, in words
`define CACHE_ADDR_WIDTH 10

// data word width
`define CACHE_DATA_WIDTH 32

// index bits, one line per set
`define CACHE_SET_BITS 3

// main memory read latency in cycles
`define CACHE_MEM_LATENCY 4

// derived sizes
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_SET_BITS)
`define CACHE_LINES (1 << `CACHE_SET_BITS)

`endif
